// File: Makefile
.PHONY: run clean

obj_dir/Vtb_opr_unit: flist.f opr_settings.svh pdp8_isa_pkg.sv opr_bus_pkg.sv opr_decode.sv \
		opr_queue.sv opr_execute.sv opr_unit.sv tb_opr_unit.sv
	verilator --binary --timing --top-module tb_opr_unit -f flist.f

run: obj_dir/Vtb_opr_unit
	./obj_dir/Vtb_opr_unit > sim.log
	cat sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// File: flist.f
+incdir+.
pdp8_isa_pkg.sv
opr_bus_pkg.sv
opr_decode.sv
opr_queue.sv
opr_execute.sv
opr_unit.sv
tb_opr_unit.sv

// File: opr_bus_pkg.sv
// operate unit transfer types between decoder, queue and executor.
package opr_bus_pkg;

    import pdp8_isa_pkg::*;

    // accepted operate word plus the switch register at strobe time.
    typedef struct packed {
        instr_u ins;
        word_t  sr;
    } opr_issue_t;

    // state after one executed word.
    typedef struct packed {
        word_t ac;
        logic  link;
        logic  skip;
        logic  halt;
    } opr_result_t;

endpackage

// File: opr_decode.sv
// operate decoder: filters strobed words and issues operate words with a switch snapshot.
`timescale 1ns/1ps

module opr_decode
    import pdp8_isa_pkg::*, opr_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       instr_valid,
    input  instr_u     instr,
    input  word_t      sr,
    output logic       issue_valid,
    output opr_issue_t issue,
    output logic       reject
);

    logic accept;

    // group 3 shares the group bit with group 2, told apart by bit 11.
    assign accept = (instr.g1.opcode == OP_OPR) && !(instr.g2.grp && instr.g2.g3);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            issue_valid <= 1'b0;
            reject      <= 1'b0;
        end
        else
        begin
            issue_valid <= instr_valid && accept;
            reject      <= instr_valid && !accept;
        end
    end

    // payload follows the strobe.
    always_ff @(posedge clk)
    begin
        if (instr_valid)
        begin
            issue.ins <= instr;
            issue.sr  <= sr;
        end
    end

endmodule

// File: opr_execute.sv
// operate executor: applies queued operate words to ac and link, with skip and halt.
`timescale 1ns/1ps

module opr_execute
    import pdp8_isa_pkg::*, opr_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  opr_issue_t  head,
    input  logic        ready,
    input  logic        cont,
    output logic        pop,
    output logic        result_valid,
    output opr_result_t result,
    output logic        halted
);

    opr_g1_t     g1;
    opr_g2_t     g2;
    logic        is_g2;
    word_t       ac;
    logic        link;
    word_t       a_clr;
    logic        l_clr;
    word_t       a_cmp;
    logic        l_cmp;
    word_t       a_inc;
    logic        carry;
    logic [12:0] lac;
    logic [12:0] rot;
    logic        any_test;
    logic        g2_skip;
    word_t       g2_ac;
    word_t       ac_next;
    logic        link_next;

    assign g1    = head.ins.g1;
    assign g2    = head.ins.g2;
    assign is_g2 = head.ins.g2.grp;
    assign pop   = ready && !halted;

    // group 1 sequence.
    always_comb
    begin
        a_clr          = g1.cla ? '0 : ac;
        l_clr          = g1.cll ? 1'b0 : link;
        a_cmp          = g1.cma ? ~a_clr : a_clr;
        l_cmp          = g1.cml ? ~l_clr : l_clr;
        {carry, a_inc} = {1'b0, a_cmp} + {12'd0, g1.iac};
        lac            = {l_cmp ^ carry, a_inc};
        // link sits above ac bit 11 in the rotate chain.
        case ({g1.rar, g1.ral, g1.rtw})
            3'b100:  rot = {lac[0], lac[12:1]};
            3'b101:  rot = {lac[1:0], lac[12:2]};
            3'b010:  rot = {lac[11:0], lac[12]};
            3'b011:  rot = {lac[10:0], lac[12:11]};
            3'b001:  rot = {lac[12], lac[5:0], lac[11:6]};
            default: rot = lac;
        endcase
    end

    // group 2 skip tests use the old ac and link.
    always_comb
    begin
        any_test = (g2.sma && ac[11]) || (g2.sza && (ac == '0)) || (g2.snl && link);
        g2_skip  = any_test ^ g2.rev;
        g2_ac    = (g2.cla ? '0 : ac) | (g2.osr ? head.sr : '0);
    end

    assign ac_next   = is_g2 ? g2_ac : rot[11:0];
    assign link_next = is_g2 ? link : rot[12];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ac           <= '0;
            link         <= 1'b0;
            result_valid <= 1'b0;
            halted       <= 1'b0;
        end
        else
        begin
            result_valid <= pop;
            if (pop)
            begin
                ac   <= ac_next;
                link <= link_next;
            end
            // cont only matters once halted.
            if (halted)
            begin
                halted <= !cont;
            end
            else
            begin
                halted <= pop && is_g2 && g2.hlt;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            result.ac   <= ac_next;
            result.link <= link_next;
            result.skip <= is_g2 && g2_skip;
            result.halt <= is_g2 && g2.hlt;
        end
    end

endmodule

// File: opr_queue.sv
// operation queue: circular FIFO of issued operate words with overflow report.
`timescale 1ns/1ps

`include "opr_settings.svh"

module opr_queue
    import opr_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       push,
    input  opr_issue_t din,
    input  logic       pop,
    output opr_issue_t head,
    output logic       ready,
    output logic       overflow
);

    localparam logic [`OPR_QUEUE_AW:0] DEPTH = `OPR_QUEUE_DEPTH;

    opr_issue_t               mem [`OPR_QUEUE_DEPTH];
    logic [`OPR_QUEUE_AW-1:0] wr_ptr;
    logic [`OPR_QUEUE_AW-1:0] rd_ptr;
    logic [`OPR_QUEUE_AW:0]   count;
    logic                     full;
    logic                     do_push;
    logic                     do_pop;

    assign full    = (count == DEPTH);
    assign ready   = (count != '0);
    assign do_push = push && !full;
    assign do_pop  = pop && ready;
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone.
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            overflow <= push && full;
        end
    end

endmodule

// File: opr_settings.svh
// operate unit settings for sizing the operation queue.
`ifndef OPR_SETTINGS_SVH
`define OPR_SETTINGS_SVH

// entries in the operation queue, a power of two.
`define OPR_QUEUE_DEPTH 8

// queue pointer width, log2 of the depth.
`define OPR_QUEUE_AW 3

`endif

// File: opr_unit.sv
// operate instruction unit: decoder, queue and executor in a row.
`timescale 1ns/1ps

module opr_unit
    import pdp8_isa_pkg::*, opr_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        instr_valid,
    input  instr_u      instr,
    input  word_t       sr,
    input  logic        cont,
    output logic        result_valid,
    output opr_result_t result,
    output logic        reject,
    output logic        overflow,
    output logic        halted
);

    logic       issue_valid;
    opr_issue_t issue;
    opr_issue_t head;
    logic       ready;
    logic       pop;

    opr_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .sr          (sr),
        .issue_valid (issue_valid),
        .issue       (issue),
        .reject      (reject)
    );

    opr_queue u_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (issue_valid),
        .din      (issue),
        .pop      (pop),
        .head     (head),
        .ready    (ready),
        .overflow (overflow)
    );

    opr_execute u_execute (
        .clk          (clk),
        .rst_n        (rst_n),
        .head         (head),
        .ready        (ready),
        .cont         (cont),
        .pop          (pop),
        .result_valid (result_valid),
        .result       (result),
        .halted       (halted)
    );

endmodule

// File: pdp8_isa_pkg.sv
// pdp-8 machine word and the two operate instruction formats.
package pdp8_isa_pkg;

    typedef logic [11:0] word_t;

    // opcode 7 marks an operate instruction.
    localparam logic [2:0] OP_OPR = 3'o7;

    // group 1 operate, group bit clear.
    typedef struct packed {
        logic [2:0] opcode;
        logic       grp;
        logic       cla;
        logic       cll;
        logic       cma;
        logic       cml;
        logic       rar;
        logic       ral;
        logic       rtw;
        logic       iac;
    } opr_g1_t;

    // group 2 operate, group bit set and last bit clear.
    typedef struct packed {
        logic [2:0] opcode;
        logic       grp;
        logic       cla;
        logic       sma;
        logic       sza;
        logic       snl;
        logic       rev;
        logic       osr;
        logic       hlt;
        logic       g3;
    } opr_g2_t;

    // same bits seen through either operate layout.
    typedef union packed {
        word_t   word;
        opr_g1_t g1;
        opr_g2_t g2;
    } instr_u;

endpackage

// File: tb_opr_unit.sv
// operate unit testbench checking random operate words against a reference model.
`timescale 1ns/1ps

`include "opr_settings.svh"

module tb_opr_unit
    import pdp8_isa_pkg::*, opr_bus_pkg::*;
();

    localparam int N_RAND  = 100;
    localparam int N_WORDS = 3 * N_RAND + `OPR_QUEUE_DEPTH + 10;
    localparam int LIMIT   = 4 * N_WORDS + 200;

    logic        clk, rst_n, instr_valid, cont;
    logic        result_valid, reject, overflow, halted;
    instr_u      instr;
    word_t       sr;
    opr_result_t result;
    opr_issue_t  exp_q[$];
    word_t       m_ac;
    logic        m_link;
    logic        stopped;
    word_t       n_reject, n_overflow, exp_reject, exp_overflow;
    integer      seed = 65387;
    int          cyc = 0;
    int          sent_cyc, last_res_cyc, res_errors, end_errors;

    opr_unit UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .sr           (sr),
        .cont         (cont),
        .result_valid (result_valid),
        .result       (result),
        .reject       (reject),
        .overflow     (overflow),
        .halted       (halted)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cyc <= cyc + 1;
        if (cyc > LIMIT)
        begin
            $display("timeout after %0d cycles, %0d results never came", LIMIT, exp_q.size());
            $display("Finished with errors");
            $finish;
        end
    end

    // reference model applying one operate word per call.
    function automatic opr_result_t model_exec(input opr_issue_t op);
        opr_result_t r;
        logic [12:0] lac;
        r = '0;
        if (!op.ins.g1.grp)
        begin
            if (op.ins.g1.cla) m_ac = '0;
            if (op.ins.g1.cll) m_link = 1'b0;
            if (op.ins.g1.cma) m_ac = ~m_ac;
            if (op.ins.g1.cml) m_link = ~m_link;
            if (op.ins.g1.iac)
            begin
                m_link = m_link ^ (m_ac == 12'o7777);
                m_ac   = m_ac + 12'd1;
            end
            lac = {m_link, m_ac};
            if (op.ins.g1.rar) repeat (op.ins.g1.rtw ? 2 : 1) lac = {lac[0], lac[12:1]};
            else if (op.ins.g1.ral) repeat (op.ins.g1.rtw ? 2 : 1) lac = {lac[11:0], lac[12]};
            else if (op.ins.g1.rtw) lac = {lac[12], lac[5:0], lac[11:6]};
            m_link = lac[12];
            m_ac   = lac[11:0];
        end
        else
        begin
            r.skip = (op.ins.g2.sma && m_ac[11]) || (op.ins.g2.sza && m_ac == 12'o0000)
                     || (op.ins.g2.snl && m_link);
            if (op.ins.g2.rev) r.skip = !r.skip;
            if (op.ins.g2.cla) m_ac = '0;
            if (op.ins.g2.osr) m_ac = m_ac | op.sr;
            r.halt = op.ins.g2.hlt;
        end
        r.ac   = m_ac;
        r.link = m_link;
        return r;
    endfunction

    // kind picks group 1 (0), group 2 (1), halt (2), group 3 (3) or another opcode (4).
    function automatic instr_u rand_word(input int kind);
        instr_u w;
        w.word = 12'($random(seed));
        if (kind == 4)
        begin
            if (w.g1.opcode == OP_OPR) w.g1.opcode = 3'o5;
            return w;
        end
        w.g1.opcode = OP_OPR;
        w.g1.grp    = (kind != 0);
        if (kind == 0 && w.g1.rar) w.g1.ral = 1'b0;
        if (kind != 0) w.g2.g3 = (kind == 3);
        if (kind == 1) w.g2.hlt = 1'b0;
        if (kind == 2) w.g2.hlt = 1'b1;
        return w;
    endfunction

    task automatic check_result(input opr_result_t exp, input opr_result_t got);
        if (got !== exp)
        begin
            $display("ERROR %0t: ac/link/skip/halt %o/%b/%b/%b, expected %o/%b/%b/%b",
                     $time, got.ac, got.link, got.skip, got.halt,
                     exp.ac, exp.link, exp.skip, exp.halt);
            res_errors++;
        end
    endtask

    task automatic check_count(input string what, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            $display("ERROR %0t: %s count %0d, expected %0d", $time, what, got, exp);
            end_errors++;
        end
    endtask

    task automatic send(input int kind, input logic keep);
        instr_u w;
        w = rand_word(kind);
        @(posedge clk);
        #1;
        instr_valid = 1'b1;
        instr       = w;
        sr          = 12'($random(seed));
        cont        = 1'b0;
        sent_cyc    = cyc;
        if (kind >= 3) exp_reject = exp_reject + 12'd1;
        else if (keep) exp_q.push_back({w, sr});
        else exp_overflow = exp_overflow + 12'd1;
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;
            instr_valid = 1'b0;
            cont        = 1'b0;
        end
    endtask

    task automatic resume();
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        cont        = 1'b1;
        idle(1);
    endtask

    task automatic wait_halt();
        idle(1);
        while (!halted) @(negedge clk);
    endtask

    task automatic drain();
        idle(1);
        while (exp_q.size() != 0) @(negedge clk);
        idle(2);
    endtask

    // results, strobes and the halt level are sampled at the falling edge.
    always @(negedge clk)
    begin
        opr_result_t exp_r;
        if (!rst_n)
        begin
            m_ac       = '0;
            m_link     = 1'b0;
            stopped    = 1'b0;
            n_reject   = '0;
            n_overflow = '0;
            res_errors = 0;
        end
        else
        begin
            if (reject) n_reject = n_reject + 12'd1;
            if (overflow) n_overflow = n_overflow + 12'd1;
            if (result_valid && (stopped || exp_q.size() == 0))
            begin
                $display("result strobe at %0t when no result was due", $time);
                res_errors++;
            end
            else if (result_valid)
            begin
                last_res_cyc = cyc;
                exp_r        = model_exec(exp_q.pop_front());
                check_result(exp_r, result);
                stopped = exp_r.halt;
            end
            // halted holds from the halt result through the cycle that carries cont.
            if (halted !== stopped)
            begin
                $display("ERROR %0t: halted=%b, expected %b", $time, halted, stopped);
                res_errors++;
            end
            if (cont) stopped = 1'b0;
        end
    end

    initial
    begin
        rst_n        = 1'b0;
        instr_valid  = 1'b0;
        cont         = 1'b0;
        instr        = '0;
        sr           = '0;
        exp_reject   = '0;
        exp_overflow = '0;
        end_errors   = 0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        send(0, 1'b1);
        drain();
        check_count("idle latency", 12'(last_res_cyc - sent_cyc), 12'd3);
        for (int k = 0; k < 2; k++)
        begin
            for (int i = 0; i < N_RAND; i++)
            begin
                send(k, 1'b1);
                if ($random(seed) & 1) idle(1);
            end
            drain();
        end
        // rejected words mixed with group 1 words.
        for (int i = 0; i < N_RAND; i++)
        begin
            send((i % 3 == 0) ? 0 : (($random(seed) & 1) ? 4 : 3), 1'b1);
        end
        drain();
        send(2, 1'b1);
        wait_halt();
        repeat (4) send(0, 1'b1);
        idle(8);
        resume();
        drain();
        // halted again so the queue fills and the rest is dropped.
        send(2, 1'b1);
        wait_halt();
        for (int i = 0; i < `OPR_QUEUE_DEPTH + 3; i++) send(0, i < `OPR_QUEUE_DEPTH);
        idle(4);
        resume();
        drain();
        check_count("reject", n_reject, exp_reject);
        check_count("overflow", n_overflow, exp_overflow);
        $display("%0d result errors, %0d count errors", res_errors, end_errors);
        if (res_errors + end_errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule
